// File: digitizer_trigger.f
trigger_pkg.sv
trigger_core.sv
event_recorder.sv
record_arbiter.sv
record_buffer.sv
digitizer_trigger.sv
trigger_properties.sv
tb_digitizer_trigger.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_digitizer_trigger
FILELIST  := digitizer_trigger.f
VFLAGS    := --binary --timing --assert -Wno-fatal
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Some tests failed
SOURCES   := $(wildcard *.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_digitizer_trigger.sv
`timescale 1ns/1ps

module tb_digitizer_trigger
    import trigger_pkg::*;
();

    localparam int HALF_PERIOD  = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int WINDOW_BEATS = 3;
    // The whole run needs well under a thousand cycles.
    localparam int MAX_CYCLES   = 4000;
    localparam int BEAT_QUIET   = 0;
    localparam int BEAT_ABOVE   = 1;
    localparam int BEAT_FALL    = 2;
    localparam int BEAT_SAT     = 3;

    logic                               ACLK;
    logic                               reset;
    logic                               set_config;
    logic                               stop;
    logic            [NUM_CHANNELS-1:0] sample_valid;
    sample_beat_s    [NUM_CHANNELS-1:0] dsp_beat;
    sample_beat_s    [NUM_CHANNELS-1:0] hg_beat;
    trigger_config_s                    trig_config;
    logic                               rd_en;
    logic            [NUM_CHANNELS-1:0] trigger;
    logic            [NUM_CHANNELS-1:0] saturation_flag;
    event_record_s                      rd_record;
    logic                               empty;
    logic            [COUNT_WIDTH-1:0]  count;
    logic                               overflow;
    logic            [NUM_CHANNELS-1:0] lost;

    trigger_config_s       cfg_a;
    trigger_config_s       cfg_b;
    logic [31:0]           lfsr_state;
    logic [TIME_WIDTH-1:0] time_count;
    int                    cycle_count;
    int                    checks;
    int                    errors;

    digitizer_trigger u_digitizer_trigger (.*);

    initial begin
        ACLK = 1'b0;
        forever #HALF_PERIOD ACLK = ~ACLK;
    end

    // Model of the free-running timestamp that the recorders latch.
    always @(posedge ACLK) begin
        if (reset) begin
            time_count <= '0;
        end else begin
            time_count <= time_count + 32'd1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge ACLK);
            cycle_count++;
        end
        $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // ###################################################################
    // Helpers
    // ###################################################################

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[14:0], feedback};
        end
        return value;
    endfunction

    function automatic int expected_length(input trigger_config_s cfg);
        return WINDOW_BEATS + int'(cfg.pre_length) + int'(cfg.post_length);
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic step_cycle();
        @(posedge ACLK);
        #DRIVE_DELAY;
    endtask

    task automatic apply_config(input trigger_config_s cfg);
        trig_config = cfg;
        set_config  = 1'b1;
        step_cycle();
        set_config  = 1'b0;
    endtask

    task automatic drive_beat(input logic [NUM_CHANNELS-1:0] mask, input int kind);
        sample_beat_s dsp;
        sample_beat_s hg;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
            // Quiet lanes sit between both thresholds and far from saturation.
            dsp.lane[i].sample   = 16'(250 + random_bits(9));
            hg.lane[i].raw.code  = 12'(random_bits(9));
            hg.lane[i].raw.pad   = 4'(random_bits(4));
            if (kind == BEAT_ABOVE)
                dsp.lane[i].sample = trig_config.rise_threshold + 16'sd100;
            if (kind == BEAT_FALL)
                dsp.lane[i].sample = trig_config.fall_threshold - 16'sd100;
        end
        if (kind == BEAT_SAT)
            hg.lane[0].raw.code = trig_config.sat_upper;
        sample_valid = mask;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (mask[ch]) begin
                dsp_beat[ch] = dsp;
                hg_beat[ch]  = hg;
            end
        end
        step_cycle();
    endtask

    // Two quiet beats, the hit beat, two hold beats and a falling beat.
    task automatic send_event(input logic [NUM_CHANNELS-1:0] mask, input int hit_kind,
                              input bit fire, output int high_time,
                              output logic [TIME_WIDTH-1:0] start_time);
        int                      hold_kind;
        int                      waited;
        logic [NUM_CHANNELS-1:0] expect_on;
        hold_kind  = (hit_kind == BEAT_SAT) ? BEAT_QUIET : BEAT_ABOVE;
        expect_on  = fire ? mask : '0;
        high_time  = 0;
        waited     = 0;
        start_time = '0;
        drive_beat(mask, BEAT_QUIET);
        drive_beat(mask, BEAT_QUIET);
        drive_beat(mask, hit_kind);
        check_value("trigger", trigger & mask, '0);
        for (int i = 0; i < 2; i++) begin
            drive_beat(mask, hold_kind);
            if (i == 0) begin
                check_value("trigger", trigger & mask, expect_on);
                start_time = time_count;
            end
            check_value("saturation_flag", saturation_flag & mask,
                        (hit_kind == BEAT_SAT && i == 1) ? mask : '0);
            if ((trigger & mask) == mask)
                high_time++;
        end
        drive_beat(mask, BEAT_FALL);
        sample_valid = '0;
        while ((trigger & mask) != '0 && waited < 200) begin
            high_time++;
            step_cycle();
            waited++;
        end
        if (waited == 200) begin
            errors++;
            $display("Trigger never fell after the end of the event");
        end
    endtask

    task automatic wait_for_count(input int target);
        int waited;
        waited = 0;
        while (count != COUNT_WIDTH'(target) && waited < 20) begin
            step_cycle();
            waited++;
        end
        if (count != COUNT_WIDTH'(target)) begin
            errors++;
            $display("Record buffer never reached %0d entries", target);
        end
    endtask

    task automatic pop_record(output event_record_s rec);
        if (empty) begin
            errors++;
            $display("Tried to read a record from an empty buffer");
        end
        rec   = rd_record;
        rd_en = 1'b1;
        step_cycle();
        rd_en = 1'b0;
    endtask

    task automatic check_record(input event_record_s rec, input logic channel,
                                input logic [TIME_WIDTH-1:0] start_time,
                                input int length, input logic saturated);
        check_value("rd_record.channel", rec.channel, channel);
        check_value("rd_record.start_time", rec.start_time, start_time);
        check_value("rd_record.length", rec.length, length);
        check_value("rd_record.saturated", rec.saturated, saturated);
    endtask

    // ###################################################################
    // Tests
    // ###################################################################

    task automatic single_crossing();
        int                    high_time;
        logic [TIME_WIDTH-1:0] start;
        event_record_s         rec;
        send_event(2'b01, BEAT_ABOVE, 1'b1, high_time, start);
        check_value("trigger high time", high_time, expected_length(cfg_a));
        wait_for_count(1);
        pop_record(rec);
        check_record(rec, 1'b0, start, expected_length(cfg_a), 1'b0);
    endtask

    task automatic stretch_length();
        int                    time_a;
        int                    time_b;
        logic [TIME_WIDTH-1:0] start;
        event_record_s         rec;
        send_event(2'b10, BEAT_ABOVE, 1'b1, time_a, start);
        wait_for_count(1);
        pop_record(rec);
        apply_config(cfg_b);
        send_event(2'b10, BEAT_ABOVE, 1'b1, time_b, start);
        wait_for_count(1);
        pop_record(rec);
        check_record(rec, 1'b1, start, expected_length(cfg_b), 1'b0);
        check_value("trigger high time change", time_b - time_a,
                    expected_length(cfg_b) - expected_length(cfg_a));
        apply_config(cfg_a);
    endtask

    task automatic saturation_trigger();
        int                    high_time;
        logic [TIME_WIDTH-1:0] start;
        event_record_s         rec;
        send_event(2'b01, BEAT_SAT, 1'b1, high_time, start);
        wait_for_count(1);
        pop_record(rec);
        check_record(rec, 1'b0, start, expected_length(cfg_a), 1'b1);
    endtask

    task automatic stop_blocks_trigger();
        int                    high_time;
        logic [TIME_WIDTH-1:0] start;
        stop = 1'b1;
        send_event(2'b01, BEAT_ABOVE, 1'b0, high_time, start);
        check_value("trigger high time", high_time, 0);
        repeat (10) begin
            step_cycle();
            check_value("empty", empty, 1'b1);
        end
        stop = 1'b0;
    endtask

    task automatic dual_channel_arbitration();
        int                    high_time;
        logic [TIME_WIDTH-1:0] start;
        event_record_s         rec_a;
        event_record_s         rec_b;
        event_record_s         rec_swap;
        send_event(2'b11, BEAT_ABOVE, 1'b1, high_time, start);
        wait_for_count(2);
        check_value("count", count, 2);
        pop_record(rec_a);
        pop_record(rec_b);
        // Grant order is up to the arbiter, so sort by channel.
        if (rec_a.channel) begin
            rec_swap = rec_a;
            rec_a    = rec_b;
            rec_b    = rec_swap;
        end
        check_record(rec_a, 1'b0, start, expected_length(cfg_a), 1'b0);
        check_record(rec_b, 1'b1, start, expected_length(cfg_a), 1'b0);
        check_value("lost", lost, '0);
    endtask

    task automatic buffer_overflow();
        logic [TIME_WIDTH-1:0] starts[$];
        logic [TIME_WIDTH-1:0] start;
        int                    high_time;
        int                    waited;
        event_record_s         rec;
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            send_event((i % 2 == 1) ? 2'b10 : 2'b01, BEAT_ABOVE, 1'b1, high_time, start);
            starts.push_back(start);
            if (i < FIFO_DEPTH)
                wait_for_count(i + 1);
        end
        waited = 0;
        while (!overflow && waited < 20) begin
            step_cycle();
            waited++;
        end
        check_value("overflow", overflow, 1'b1);
        check_value("count", count, FIFO_DEPTH);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_record(rec);
            check_record(rec, 1'(i % 2), starts[i], expected_length(cfg_a), 1'b0);
        end
        check_value("empty", empty, 1'b1);
        check_value("overflow", overflow, 1'b1);
    endtask

    initial begin
        lfsr_state             = 32'h6cfb;
        checks                 = 0;
        errors                 = 0;
        cfg_a.rise_threshold   = 16'sd1000;
        cfg_a.fall_threshold   = 16'sd200;
        cfg_a.pre_length       = 6'd3;
        cfg_a.post_length      = 6'd5;
        cfg_a.sat_upper        = 12'sd2000;
        cfg_a.sat_lower        = -12'sd2000;
        cfg_b                  = cfg_a;
        cfg_b.pre_length       = 6'd10;
        cfg_b.post_length      = 6'd12;
        reset                  = 1'b1;
        set_config             = 1'b0;
        stop                   = 1'b0;
        sample_valid           = '0;
        dsp_beat               = '0;
        hg_beat                = '0;
        trig_config            = cfg_a;
        rd_en                  = 1'b0;
        repeat (10) @(posedge ACLK);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_value("trigger", trigger, '0);
        check_value("saturation_flag", saturation_flag, '0);
        check_value("empty", empty, 1'b1);
        check_value("overflow", overflow, 1'b0);
        apply_config(cfg_a);
        single_crossing();
        stretch_length();
        saturation_trigger();
        stop_blocks_trigger();
        dual_channel_arbitration();
        buffer_overflow();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 u_digitizer_trigger.u_trigger_properties.failure_count);
        if (errors == 0 && u_digitizer_trigger.u_trigger_properties.failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: trigger_properties.sv
`timescale 1ns/1ps

module trigger_properties
    import trigger_pkg::*;
(
    input logic                    ACLK,
    input logic                    reset,
    input logic                    set_config,
    input logic [NUM_CHANNELS-1:0] grant,
    input logic                    wr_en,
    input logic                    overflow,
    input logic [NUM_CHANNELS-1:0] trigger,
    input logic [NUM_CHANNELS-1:0] window
);

    int failure_count = 0;

    grant_onehot: assert property (@(posedge ACLK) disable iff (reset) $onehot0(grant))
        else begin
            failure_count++;
            $error("More than one channel granted in the same cycle.");
        end

    no_write_in_reset: assert property (@(posedge ACLK) reset |-> !$rose(wr_en))
        else begin
            failure_count++;
            $error("Buffer write started during reset.");
        end

    overflow_sticky: assert property (@(posedge ACLK) disable iff (reset) !$fell(overflow))
        else begin
            failure_count++;
            $error("Overflow dropped while out of reset.");
        end

    // The stretch keeps the trigger up after the window, so the window must
    // already be closed in the last high cycle. A new configuration may cut
    // both at once.
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        fall_after_window: assert property (
            @(posedge ACLK) disable iff (reset)
            $fell(trigger[ch]) && !$past(set_config) |-> !$past(window[ch])
        ) else begin
            failure_count++;
            $error("Trigger fell while its window was still open.");
        end
    end

endmodule

bind digitizer_trigger trigger_properties u_trigger_properties (
    .ACLK       (ACLK),
    .reset      (reset),
    .set_config (set_config),
    .grant      (grant),
    .wr_en      (wr_en),
    .overflow   (overflow),
    .trigger    (trigger),
    .window     ({g_channel[1].u_trigger_core.window, g_channel[0].u_trigger_core.window})
);

// File: digitizer_trigger.sv
`timescale 1ns/1ps

module digitizer_trigger
    import trigger_pkg::*;
(
    input  logic                                ACLK,
    input  logic                                reset,
    input  logic                                set_config,
    input  logic                                stop,
    input  logic            [NUM_CHANNELS-1:0]  sample_valid,
    input  sample_beat_s    [NUM_CHANNELS-1:0]  dsp_beat,
    input  sample_beat_s    [NUM_CHANNELS-1:0]  hg_beat,
    input  trigger_config_s                     trig_config,
    input  logic                                rd_en,
    output logic            [NUM_CHANNELS-1:0]  trigger,
    output logic            [NUM_CHANNELS-1:0]  saturation_flag,
    output event_record_s                       rd_record,
    output logic                                empty,
    output logic            [COUNT_WIDTH-1:0]   count,
    output logic                                overflow,
    output logic            [NUM_CHANNELS-1:0]  lost
);

    logic          [NUM_CHANNELS-1:0] pending;
    logic          [NUM_CHANNELS-1:0] grant;
    event_record_s [NUM_CHANNELS-1:0] record;
    logic                             wr_en;
    event_record_s                    wr_record;

    // ###################################################################
    // Per-channel trigger and recorder
    // ###################################################################

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        trigger_core u_trigger_core (
            .ACLK            (ACLK),
            .reset           (reset),
            .set_config      (set_config),
            .stop            (stop),
            .sample_valid    (sample_valid[ch]),
            .dsp_beat        (dsp_beat[ch]),
            .hg_beat         (hg_beat[ch]),
            .trig_config     (trig_config),
            .trigger         (trigger[ch]),
            .saturation_flag (saturation_flag[ch])
        );

        event_recorder u_event_recorder (
            .ACLK            (ACLK),
            .reset           (reset),
            .channel_id      (1'(ch)),
            .trigger         (trigger[ch]),
            .saturation_flag (saturation_flag[ch]),
            .grant           (grant[ch]),
            .pending         (pending[ch]),
            .record          (record[ch]),
            .lost            (lost[ch])
        );
    end

    // ###################################################################
    // Shared record path
    // ###################################################################

    record_arbiter u_record_arbiter (
        .ACLK      (ACLK),
        .reset     (reset),
        .pending   (pending),
        .record    (record),
        .grant     (grant),
        .wr_en     (wr_en),
        .wr_record (wr_record)
    );

    record_buffer u_record_buffer (
        .ACLK      (ACLK),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_record (wr_record),
        .rd_en     (rd_en),
        .rd_record (rd_record),
        .empty     (empty),
        .count     (count),
        .overflow  (overflow)
    );

endmodule

// File: record_buffer.sv
`timescale 1ns/1ps

module record_buffer
    import trigger_pkg::*;
(
    input  logic                   ACLK,
    input  logic                   reset,
    input  logic                   wr_en,
    input  event_record_s          wr_record,
    input  logic                   rd_en,
    output event_record_s          rd_record,
    output logic                   empty,
    output logic [COUNT_WIDTH-1:0] count,
    output logic                   overflow
);

    event_record_s        mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 full;
    logic                 do_write;
    logic                 do_read;

    assign full     = (count == COUNT_WIDTH'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    always_ff @(posedge ACLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_record;
        end
    end

    // Pointers wrap naturally since the depth is a power of two.
    always_ff @(posedge ACLK) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

    assign rd_record = mem[rd_ptr];

endmodule

// File: record_arbiter.sv
`timescale 1ns/1ps

module record_arbiter
    import trigger_pkg::*;
(
    input  logic                               ACLK,
    input  logic                               reset,
    input  logic          [NUM_CHANNELS-1:0]   pending,
    input  event_record_s [NUM_CHANNELS-1:0]   record,
    output logic          [NUM_CHANNELS-1:0]   grant,
    output logic                               wr_en,
    output event_record_s                      wr_record
);

    logic rr_ptr;
    logic both_pending;

    assign both_pending = &pending;

    // With a single request the grant goes straight through. On a tie the
    // pointer picks the channel.
    always_comb begin
        grant = '0;
        if (both_pending) begin
            grant[rr_ptr] = 1'b1;
        end else begin
            grant = pending;
        end
    end

    assign wr_en     = |pending;
    assign wr_record = grant[1] ? record[1] : record[0];

    // The pointer moves only on a tie, so the loser is served next cycle.
    always_ff @(posedge ACLK) begin
        if (reset) begin
            rr_ptr <= 1'b0;
        end else if (both_pending) begin
            rr_ptr <= !rr_ptr;
        end
    end

endmodule

// File: event_recorder.sv
`timescale 1ns/1ps

module event_recorder
    import trigger_pkg::*;
(
    input  logic          ACLK,
    input  logic          reset,
    input  logic          channel_id,
    input  logic          trigger,
    input  logic          saturation_flag,
    input  logic          grant,
    output logic          pending,
    output event_record_s record,
    output logic          lost
);

    logic [TIME_WIDTH-1:0]       timestamp;
    logic                        trigger_d;
    logic                        trigger_rise;
    logic                        trigger_fall;
    logic                        accept;
    logic [TIME_WIDTH-1:0]       start_time;
    logic [RECORD_LEN_WIDTH-1:0] length_count;
    logic                        sat_seen;

    assign trigger_rise = trigger && !trigger_d;
    assign trigger_fall = !trigger && trigger_d;

    // A finished window is taken if the hold slot is free or being granted.
    assign accept = trigger_fall && (!pending || grant);

    always_ff @(posedge ACLK) begin
        if (reset) begin
            timestamp <= '0;
            trigger_d <= 1'b0;
        end else begin
            timestamp <= timestamp + 1'b1;
            trigger_d <= trigger;
        end
    end

    // Length saturates at its maximum rather than wrapping.
    always_ff @(posedge ACLK) begin
        if (trigger_rise) begin
            start_time   <= timestamp;
            length_count <= RECORD_LEN_WIDTH'(1);
            sat_seen     <= saturation_flag;
        end else if (trigger) begin
            if (length_count != '1) begin
                length_count <= length_count + 1'b1;
            end
            sat_seen <= sat_seen || saturation_flag;
        end
    end

    always_ff @(posedge ACLK) begin
        if (reset) begin
            pending <= 1'b0;
            lost    <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (trigger_fall) begin
            lost <= 1'b1;
        end else if (grant) begin
            pending <= 1'b0;
        end
    end

    // The flag lags the trigger by a cycle, so it is sampled once more here.
    always_ff @(posedge ACLK) begin
        if (accept) begin
            record.channel    <= channel_id;
            record.start_time <= start_time;
            record.length     <= length_count;
            record.saturated  <= sat_seen || saturation_flag;
        end
    end

endmodule

// File: trigger_core.sv
`timescale 1ns/1ps

module trigger_core
    import trigger_pkg::*;
(
    input  logic            ACLK,
    input  logic            reset,
    input  logic            set_config,
    input  logic            stop,
    input  logic            sample_valid,
    input  sample_beat_s    dsp_beat,
    input  sample_beat_s    hg_beat,
    input  trigger_config_s trig_config,
    output logic            trigger,
    output logic            saturation_flag
);

    logic [SAMPLES_PER_BEAT-1:0] rise_over;
    logic [SAMPLES_PER_BEAT-1:0] rise_over_prev;
    logic [SAMPLES_PER_BEAT-1:0] fall_under;
    logic [SAMPLES_PER_BEAT-1:0] sat_lane;
    logic                        crossing;
    logic                        hit_d1;
    logic                        end_d1;
    logic                        clear;
    logic                        window;
    logic [STRETCH_WIDTH-1:0]    stretch_load;
    logic [STRETCH_WIDTH-1:0]    stretch_count;
    logic                        sat_d1;
    logic                        sat_d2;
    logic                        sat_d3;

    // A new configuration restarts the trigger logic just like a reset.
    assign clear = reset || set_config;

    // ###################################################################
    // Hit detection
    // ###################################################################

    // The processed stream is read as signed samples, the high-gain stream
    // as left aligned ADC codes.
    always_comb begin
        for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
            rise_over[i]  = dsp_beat.lane[i].sample > trig_config.rise_threshold;
            fall_under[i] = dsp_beat.lane[i].sample < trig_config.fall_threshold;
            sat_lane[i]   = (hg_beat.lane[i].raw.code >= trig_config.sat_upper) ||
                            (hg_beat.lane[i].raw.code <= trig_config.sat_lower);
        end
    end

    // Only the first beat of a run above threshold counts as a crossing.
    assign crossing = (&rise_over) && !(&rise_over_prev);

    always_ff @(posedge ACLK) begin
        if (reset) begin
            rise_over_prev <= '0;
            hit_d1         <= 1'b0;
            end_d1         <= 1'b0;
        end else begin
            hit_d1 <= sample_valid && (crossing || (|sat_lane));
            end_d1 <= sample_valid && (&fall_under);
            if (sample_valid) begin
                rise_over_prev <= rise_over;
            end
        end
    end

    // ###################################################################
    // Trigger window and stretch
    // ###################################################################

    // Set wins over clear, so a saturating beat that is also below the
    // falling threshold still opens a window.
    always_ff @(posedge ACLK) begin
        if (clear) begin
            window <= 1'b0;
        end else if (hit_d1 && !stop) begin
            window <= 1'b1;
        end else if (end_d1) begin
            window <= 1'b0;
        end
    end

    assign stretch_load = STRETCH_WIDTH'(trig_config.pre_length) +
                          STRETCH_WIDTH'(trig_config.post_length);

    // The counter is held at its load value while the window is open and
    // runs down once it closes.
    always_ff @(posedge ACLK) begin
        if (clear) begin
            stretch_count <= '0;
        end else if (window) begin
            stretch_count <= stretch_load;
        end else if (stretch_count != '0) begin
            stretch_count <= stretch_count - 1'b1;
        end
    end

    assign trigger = window || (stretch_count != '0);

    // ###################################################################
    // High-gain saturation
    // ###################################################################

    always_ff @(posedge ACLK) begin
        if (clear) begin
            sat_d1 <= 1'b0;
            sat_d2 <= 1'b0;
            sat_d3 <= 1'b0;
        end else begin
            sat_d1 <= sample_valid && (|sat_lane);
            sat_d2 <= sat_d1;
            sat_d3 <= sat_d2;
        end
    end

    assign saturation_flag = sat_d3;

endmodule

// File: trigger_pkg.sv
package trigger_pkg;

    // ###################################################################
    // Sizes
    // ###################################################################

    localparam int NUM_CHANNELS     = 2;
    localparam int SAMPLES_PER_BEAT = 4;
    localparam int SAMPLE_WIDTH     = 16;
    localparam int ADC_WIDTH        = 12;
    localparam int PAD_WIDTH        = SAMPLE_WIDTH - ADC_WIDTH;
    localparam int BEAT_WIDTH       = SAMPLES_PER_BEAT * SAMPLE_WIDTH;
    localparam int LEN_WIDTH        = 6;
    localparam int STRETCH_WIDTH    = LEN_WIDTH + 1;
    localparam int TIME_WIDTH       = 32;
    localparam int RECORD_LEN_WIDTH = 13;
    localparam int FIFO_DEPTH       = 16;
    localparam int PTR_WIDTH        = $clog2(FIFO_DEPTH);
    localparam int COUNT_WIDTH      = PTR_WIDTH + 1;

    // ###################################################################
    // Sample lanes
    // ###################################################################

    // The ADC code is left aligned in its lane, with the pad bits below it.
    typedef struct packed {
        logic signed [ADC_WIDTH-1:0] code;
        logic        [PAD_WIDTH-1:0] pad;
    } raw_code_s;

    typedef union packed {
        logic signed [SAMPLE_WIDTH-1:0] sample;
        raw_code_s                      raw;
    } sample_lane_u;

    // Lane 0 sits in the low bits and is the oldest sample of the beat.
    typedef struct packed {
        sample_lane_u [SAMPLES_PER_BEAT-1:0] lane;
    } sample_beat_s;

    // ###################################################################
    // Configuration and records
    // ###################################################################

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] rise_threshold;
        logic signed [SAMPLE_WIDTH-1:0] fall_threshold;
        logic        [LEN_WIDTH-1:0]    pre_length;
        logic        [LEN_WIDTH-1:0]    post_length;
        logic signed [ADC_WIDTH-1:0]    sat_upper;
        logic signed [ADC_WIDTH-1:0]    sat_lower;
    } trigger_config_s;

    typedef struct packed {
        logic                        channel;
        logic [TIME_WIDTH-1:0]       start_time;
        logic [RECORD_LEN_WIDTH-1:0] length;
        logic                        saturated;
    } event_record_s;

endpackage
